// File: upsizer_consts.svh
// Widths fixed for a 4-byte narrow to 16-byte wide write upsizer; descriptor FIFO depth must be >= 1
`ifndef UPSIZER_CONSTS_SVH
`define UPSIZER_CONSTS_SVH

// Address and ID widths
`define UPS_ADDR_WIDTH 32
`define UPS_ID_WIDTH 4

// Data widths in bytes on either side
// Wide side must be a power-of-two multiple of the narrow side
`define UPS_NARROW_BYTES 4
`define UPS_WIDE_BYTES 16

// Bursts whose addresses may run ahead of their data
`define UPS_DESC_DEPTH 4

// AXI burst type encoding for INCR
`define UPS_BURST_INCR 2'b01

// Modifiable bit of AxCACHE, which allows beats to be merged
`define UPS_CACHE_MODIFIABLE 4'b0010

`endif

// File: upsizer_pkg.sv
// Types for the write upsizer; all widths come from upsizer_consts.svh, no user/lock/prot/qos fields
`include "upsizer_consts.svh"

package upsizer_pkg;

  typedef logic [`UPS_ADDR_WIDTH-1:0]       addr_t;
  typedef logic [`UPS_ID_WIDTH-1:0]         id_t;
  typedef logic [7:0]                       len_t;
  typedef logic [2:0]                       size_t;
  typedef logic [1:0]                       burst_t;
  typedef logic [3:0]                       cache_t;
  typedef logic [1:0]                       resp_t;
  typedef logic [8*`UPS_NARROW_BYTES-1:0]   narrow_data_t;
  typedef logic [`UPS_NARROW_BYTES-1:0]     narrow_strb_t;
  typedef logic [8*`UPS_WIDE_BYTES-1:0]     wide_data_t;
  typedef logic [`UPS_WIDE_BYTES-1:0]       wide_strb_t;

  // Write address channel, same layout on both sides
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    cache_t cache;
  } aw_chan_t;

  typedef struct packed {
    narrow_data_t data;
    narrow_strb_t strb;
  } narrow_w_t;

  typedef struct packed {
    wide_data_t data;
    wide_strb_t strb;
    logic       last;
  } wide_w_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef enum logic [1:0] {
    PACK_PASSTHROUGH,
    PACK_UPSIZE
  } pack_mode_t;

  // Narrow view of one burst, handed from address side to data side
  typedef struct packed {
    addr_t      start_addr;
    len_t       len;
    size_t      size;
    pack_mode_t pack_mode;
  } burst_desc_t;

  typedef enum logic [1:0] {
    PK_IDLE,
    PK_PASSTHROUGH,
    PK_UPSIZE
  } pack_state_t;

endpackage

// File: burst_planner.sv
// Upsizes only modifiable INCR bursts; FIXED and WRAP keep their narrow len and size on the wide side
`timescale 1ns/1ps

`include "upsizer_consts.svh"

module burst_planner import upsizer_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  aw_chan_t    slv_aw_i,
  input  logic        slv_aw_valid_i,
  output logic        slv_aw_ready_o,
  output aw_chan_t    mst_aw_o,
  output logic        mst_aw_valid_o,
  input  logic        mst_aw_ready_i,
  input  logic        desc_full_i,
  output logic        desc_push_o,
  output burst_desc_t desc_o
);

  localparam int unsigned wide_size = $clog2(`UPS_WIDE_BYTES);
  localparam addr_t       wide_mask = addr_t'(`UPS_WIDE_BYTES - 1);

  aw_chan_t aw_d;
  aw_chan_t aw_q;
  logic     aw_valid_q;
  logic     aw_hs;
  logic     upsize;
  addr_t    size_mask;
  addr_t    addr_start;
  addr_t    addr_end;
  addr_t    wide_span;

  // Take a new request only if the slot frees up and the descriptor has room
  assign slv_aw_ready_o = (!aw_valid_q || mst_aw_ready_i) && !desc_full_i;
  assign aw_hs          = slv_aw_valid_i && slv_aw_ready_o;

  assign upsize = (|(slv_aw_i.cache & cache_t'(`UPS_CACHE_MODIFIABLE))) &&
                  (slv_aw_i.burst == burst_t'(`UPS_BURST_INCR));

  always_comb begin
    size_mask  = (addr_t'(1) << slv_aw_i.size) - addr_t'(1);
    addr_start = slv_aw_i.addr & ~wide_mask;
    // Last narrow beat address, brought down to its wide word
    addr_end   = (slv_aw_i.addr & ~size_mask) + (addr_t'(slv_aw_i.len) << slv_aw_i.size);
    addr_end   = addr_end & ~wide_mask;
    wide_span  = (addr_end - addr_start) >> wide_size;

    aw_d = slv_aw_i;
    if (upsize) begin
      aw_d.len  = len_t'(wide_span);
      aw_d.size = size_t'(wide_size);
    end
  end

  // Descriptor keeps the narrow view for the packer
  always_comb begin
    desc_o.start_addr = slv_aw_i.addr;
    desc_o.len        = slv_aw_i.len;
    desc_o.size       = slv_aw_i.size;
    desc_o.pack_mode  = upsize ? PACK_UPSIZE : PACK_PASSTHROUGH;
  end

  assign desc_push_o = aw_hs;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_valid_q <= 1'b0;
    end else if (aw_hs) begin
      aw_valid_q <= 1'b1;
    end else if (mst_aw_ready_i) begin
      aw_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      aw_q <= aw_d;
    end
  end

  assign mst_aw_o       = aw_q;
  assign mst_aw_valid_o = aw_valid_q;

endmodule

// File: burst_desc_fifo.sv
// Descriptor FIFO; push while full and pop while empty are ignored, head is valid only when not empty
`timescale 1ns/1ps

`include "upsizer_consts.svh"

module burst_desc_fifo import upsizer_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        push_i,
  input  burst_desc_t desc_i,
  input  logic        pop_i,
  output logic        full_o,
  output logic        not_empty_o,
  output burst_desc_t desc_o
);

  localparam int unsigned depth = `UPS_DESC_DEPTH;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  burst_desc_t            mem_q [depth];
  logic [ptr_w-1:0]       wr_ptr_q;
  logic [ptr_w-1:0]       rd_ptr_q;
  logic [cnt_w-1:0]       count_q;
  logic                   do_push;
  logic                   do_pop;

  assign full_o      = (count_q == cnt_w'(depth));
  assign not_empty_o = (count_q != '0);
  assign desc_o      = mem_q[rd_ptr_q];

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && not_empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the level unchanged
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= desc_i;
    end
  end

endmodule

// File: write_packer.sv
// Counts narrow beats from the descriptor; the narrow W last flag is not used, size must not exceed narrow width
`timescale 1ns/1ps

`include "upsizer_consts.svh"

module write_packer import upsizer_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  burst_desc_t desc_i,
  input  logic        desc_valid_i,
  output logic        desc_pop_o,
  input  narrow_w_t   slv_w_i,
  input  logic        slv_w_valid_i,
  output logic        slv_w_ready_o,
  output wide_w_t     mst_w_o,
  output logic        mst_w_valid_o,
  input  logic        mst_w_ready_i
);

  localparam int unsigned narrow_offs_w = $clog2(`UPS_NARROW_BYTES);
  localparam int unsigned wide_offs_w   = $clog2(`UPS_WIDE_BYTES);

  pack_state_t state_d;
  pack_state_t state_q;
  addr_t       addr_q;
  len_t        len_q;
  size_t       size_q;
  wide_data_t  acc_data_q;
  wide_strb_t  acc_strb_q;
  wide_data_t  steer_data;
  wide_strb_t  steer_strb;
  wide_w_t     out_q;
  logic        out_valid_q;
  addr_t       size_mask;
  addr_t       next_addr;
  logic        w_hs;
  logic        close_beat;
  logic        last_beat;
  int          lane_base;

  assign desc_pop_o    = (state_q == PK_IDLE) && desc_valid_i;
  assign slv_w_ready_o = (state_q != PK_IDLE) && (!out_valid_q || mst_w_ready_i);
  assign w_hs          = slv_w_valid_i && slv_w_ready_o;

  // Address of the following narrow beat, INCR style for all burst types
  assign size_mask = (addr_t'(1) << size_q) - addr_t'(1);
  assign next_addr = (addr_q & ~size_mask) + (addr_t'(1) << size_q);

  assign last_beat  = (len_q == '0);
  assign close_beat = (state_q == PK_PASSTHROUGH) || last_beat ||
                      (next_addr[`UPS_ADDR_WIDTH-1:wide_offs_w] !=
                       addr_q[`UPS_ADDR_WIDTH-1:wide_offs_w]);

  // Merge the narrow beat into the accumulated wide word
  always_comb begin
    lane_base  = int'(addr_q[wide_offs_w-1:0]) - int'(addr_q[narrow_offs_w-1:0]);
    steer_data = acc_data_q;
    steer_strb = acc_strb_q;
    for (int j = 0; j < `UPS_NARROW_BYTES; j++) begin
      if ((j >= int'(addr_q[narrow_offs_w-1:0])) &&
          (j - int'(addr_q[narrow_offs_w-1:0]) < (1 << size_q))) begin
        steer_data[8*(lane_base + j) +: 8] = slv_w_i.data[8*j +: 8];
        steer_strb[lane_base + j]          = slv_w_i.strb[j];
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      PK_IDLE: begin
        if (desc_valid_i) begin
          state_d = (desc_i.pack_mode == PACK_UPSIZE) ? PK_UPSIZE : PK_PASSTHROUGH;
        end
      end
      PK_PASSTHROUGH, PK_UPSIZE: begin
        if (w_hs && last_beat) begin
          state_d = PK_IDLE;
        end
      end
      default: state_d = PK_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= PK_IDLE;
      out_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (w_hs && close_beat) begin
        out_valid_q <= 1'b1;
      end else if (mst_w_ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (desc_pop_o) begin
      addr_q     <= desc_i.start_addr;
      len_q      <= desc_i.len;
      size_q     <= desc_i.size;
      acc_data_q <= '0;
      acc_strb_q <= '0;
    end else if (w_hs) begin
      addr_q <= next_addr;
      len_q  <= len_q - 1'b1;
      if (close_beat) begin
        out_q.data <= steer_data;
        out_q.strb <= steer_strb;
        out_q.last <= last_beat;
        // Next wide word starts empty
        acc_data_q <= '0;
        acc_strb_q <= '0;
      end else begin
        acc_data_q <= steer_data;
        acc_strb_q <= steer_strb;
      end
    end
  end

  assign mst_w_o       = out_q;
  assign mst_w_valid_o = out_valid_q;

endmodule

// File: dw_write_upsizer.sv
// Write-only AXI upsizer, narrow master to wide slave; no read path, B passes through combinationally
`timescale 1ns/1ps

`include "upsizer_consts.svh"

module dw_write_upsizer import upsizer_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  aw_chan_t  slv_aw_i,
  input  logic      slv_aw_valid_i,
  output logic      slv_aw_ready_o,
  input  narrow_w_t slv_w_i,
  input  logic      slv_w_valid_i,
  output logic      slv_w_ready_o,
  output b_chan_t   slv_b_o,
  output logic      slv_b_valid_o,
  input  logic      slv_b_ready_i,
  output aw_chan_t  mst_aw_o,
  output logic      mst_aw_valid_o,
  input  logic      mst_aw_ready_i,
  output wide_w_t   mst_w_o,
  output logic      mst_w_valid_o,
  input  logic      mst_w_ready_i,
  input  b_chan_t   mst_b_i,
  input  logic      mst_b_valid_i,
  output logic      mst_b_ready_o
);

  logic        desc_push;
  logic        desc_pop;
  logic        desc_full;
  logic        desc_not_empty;
  burst_desc_t push_desc;
  burst_desc_t head_desc;

  burst_planner burst_planner_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_i       (slv_aw_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .mst_aw_o       (mst_aw_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .desc_full_i    (desc_full),
    .desc_push_o    (desc_push),
    .desc_o         (push_desc)
  );

  burst_desc_fifo burst_desc_fifo_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (desc_push),
    .desc_i      (push_desc),
    .pop_i       (desc_pop),
    .full_o      (desc_full),
    .not_empty_o (desc_not_empty),
    .desc_o      (head_desc)
  );

  write_packer write_packer_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .desc_i        (head_desc),
    .desc_valid_i  (desc_not_empty),
    .desc_pop_o    (desc_pop),
    .slv_w_i       (slv_w_i),
    .slv_w_valid_i (slv_w_valid_i),
    .slv_w_ready_o (slv_w_ready_o),
    .mst_w_o       (mst_w_o),
    .mst_w_valid_o (mst_w_valid_o),
    .mst_w_ready_i (mst_w_ready_i)
  );

  // B needs no conversion
  assign slv_b_o       = mst_b_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

endmodule

// File: tb_dw_write_upsizer.sv
// Self-checking bench for the write upsizer; narrow beats carry full strobes and sizes stay <= 4 bytes
`timescale 1ns/1ps

`include "upsizer_consts.svh"

module tb_dw_write_upsizer import upsizer_pkg::*; ();

  localparam int unsigned num_rows       = 10;
  localparam int unsigned timeout_cycles = 200 * num_rows + 100;
  localparam int unsigned narrow_bytes   = `UPS_NARROW_BYTES;
  localparam int unsigned wide_bytes     = `UPS_WIDE_BYTES;
  localparam burst_t      burst_fixed    = 2'b00;
  localparam burst_t      burst_incr     = `UPS_BURST_INCR;
  localparam burst_t      burst_wrap     = 2'b10;

  typedef struct packed {
    id_t        id;
    addr_t      addr;
    len_t       len;
    size_t      size;
    burst_t     burst;
    cache_t     cache;
    logic [7:0] seed;
  } stim_row_t;

  logic        clk_i;
  logic        rst_ni;
  aw_chan_t    slv_aw_i;
  logic        slv_aw_valid_i;
  logic        slv_aw_ready_o;
  narrow_w_t   slv_w_i;
  logic        slv_w_valid_i;
  logic        slv_w_ready_o;
  b_chan_t     slv_b_o;
  logic        slv_b_valid_o;
  logic        slv_b_ready_i;
  aw_chan_t    mst_aw_o;
  logic        mst_aw_valid_o;
  logic        mst_aw_ready_i;
  wide_w_t     mst_w_o;
  logic        mst_w_valid_o;
  logic        mst_w_ready_i;
  b_chan_t     mst_b_i;
  logic        mst_b_valid_i;
  logic        mst_b_ready_o;

  stim_row_t   stim_table [num_rows];
  aw_chan_t    exp_aw [$];
  wide_w_t     exp_w [$];
  int unsigned cycle_count;
  logic        aw_done;
  logic        w_done;

  dw_write_upsizer dw_write_upsizer_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_i       (slv_aw_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .slv_w_i        (slv_w_i),
    .slv_w_valid_i  (slv_w_valid_i),
    .slv_w_ready_o  (slv_w_ready_o),
    .slv_b_o        (slv_b_o),
    .slv_b_valid_o  (slv_b_valid_o),
    .slv_b_ready_i  (slv_b_ready_i),
    .mst_aw_o       (mst_aw_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .mst_w_o        (mst_w_o),
    .mst_w_valid_o  (mst_w_valid_o),
    .mst_w_ready_i  (mst_w_ready_i),
    .mst_b_i        (mst_b_i),
    .mst_b_valid_i  (mst_b_valid_i),
    .mst_b_ready_o  (mst_b_ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [159:0] actual,
                             input logic [159:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic load_table();
    // id, addr, len, size, burst, cache, data seed
    stim_table[0] = '{4'h1, 32'h0000_1000, 8'd7,  3'd2, burst_incr,  4'b0011, 8'h10};
    stim_table[1] = '{4'h2, 32'h0000_2006, 8'd4,  3'd2, burst_incr,  4'b0010, 8'h20};
    stim_table[2] = '{4'h3, 32'h0000_3004, 8'd3,  3'd2, burst_incr,  4'b0000, 8'h30};
    stim_table[3] = '{4'h4, 32'h0000_4008, 8'd2,  3'd2, burst_fixed, 4'b0010, 8'h40};
    stim_table[4] = '{4'h5, 32'h0000_5003, 8'd9,  3'd0, burst_incr,  4'b0010, 8'h50};
    stim_table[5] = '{4'h6, 32'h0000_600e, 8'd5,  3'd1, burst_incr,  4'b0010, 8'h60};
    stim_table[6] = '{4'h7, 32'h0000_7000, 8'd15, 3'd2, burst_incr,  4'b1111, 8'h70};
    stim_table[7] = '{4'h8, 32'h0000_8001, 8'd2,  3'd0, burst_incr,  4'b0000, 8'h80};
    stim_table[8] = '{4'h9, 32'h0000_9010, 8'd3,  3'd1, burst_wrap,  4'b0010, 8'h90};
    stim_table[9] = '{4'ha, 32'h0000_a000, 8'd0,  3'd2, burst_incr,  4'b0010, 8'ha0};
  endtask

  function automatic aw_chan_t row_request(input stim_row_t row);
    return '{row.id, row.addr, row.len, row.size, row.burst, row.cache};
  endfunction

  function automatic logic is_upsized(input stim_row_t row);
    return ((row.cache & cache_t'(`UPS_CACHE_MODIFIABLE)) != '0) && (row.burst == burst_incr);
  endfunction

  // Byte values climb from the row seed so misplaced lanes show up
  function automatic narrow_w_t narrow_beat(input stim_row_t row, input int unsigned beat);
    narrow_w_t nb;
    nb.strb = '1;
    for (int unsigned j = 0; j < narrow_bytes; j++) begin
      nb.data[5'(8 * j) +: 8] = 8'(32'(row.seed) + beat * narrow_bytes + j);
    end
    return nb;
  endfunction

  function automatic aw_chan_t expected_aw(input stim_row_t row);
    aw_chan_t aw;
    addr_t    last_addr;
    aw = row_request(row);
    if (is_upsized(row)) begin
      // Final narrow beat, counted from the size-aligned start
      last_addr = ((row.addr >> row.size) << row.size) + (addr_t'(row.len) << row.size);
      aw.len    = len_t'(last_addr / wide_bytes - row.addr / wide_bytes);
      aw.size   = size_t'($clog2(wide_bytes));
    end
    return aw;
  endfunction

  task automatic queue_expected_w(input stim_row_t row);
    wide_w_t     beat;
    narrow_w_t   nb;
    addr_t       addr;
    addr_t       nxt;
    int unsigned step;
    int unsigned n;
    int unsigned a;
    int unsigned lane;
    addr = row.addr;
    step = 32'd1 << row.size;
    beat = '0;
    for (int unsigned k = 0; k <= 32'(row.len); k++) begin
      nb = narrow_beat(row, k);
      n  = addr % narrow_bytes;
      a  = addr % wide_bytes;
      for (int unsigned j = n; (j < narrow_bytes) && (j < n + step); j++) begin
        lane = a + j - n;
        beat.data[7'(8 * lane) +: 8] = nb.data[5'(8 * j) +: 8];
        beat.strb[4'(lane)]          = nb.strb[2'(j)];
      end
      nxt = (addr & ~addr_t'(step - 1)) + step;
      if (!is_upsized(row) || (k == 32'(row.len)) || (nxt / wide_bytes != addr / wide_bytes)) begin
        beat.last = (k == 32'(row.len));
        exp_w.push_back(beat);
        beat = '0;
      end
      addr = nxt;
    end
  endtask

  task automatic check_aw_beat();
    if (exp_aw.size() == 0) begin
      abort_run("A wide AW request came out with no request outstanding");
    end else begin
      check_value("mst_aw_o.id", 160'(mst_aw_o.id), 160'(exp_aw[0].id));
      check_value("mst_aw_o.addr", 160'(mst_aw_o.addr), 160'(exp_aw[0].addr));
      check_value("mst_aw_o.len", 160'(mst_aw_o.len), 160'(exp_aw[0].len));
      check_value("mst_aw_o.size", 160'(mst_aw_o.size), 160'(exp_aw[0].size));
      check_value("mst_aw_o.burst", 160'(mst_aw_o.burst), 160'(exp_aw[0].burst));
      check_value("mst_aw_o.cache", 160'(mst_aw_o.cache), 160'(exp_aw[0].cache));
      void'(exp_aw.pop_front());
    end
  endtask

  task automatic check_w_beat();
    if (exp_w.size() == 0) begin
      abort_run("A wide W beat came out with no beat outstanding");
    end else begin
      check_value("mst_w_o.data", 160'(mst_w_o.data), 160'(exp_w[0].data));
      check_value("mst_w_o.strb", 160'(mst_w_o.strb), 160'(exp_w[0].strb));
      check_value("mst_w_o.last", 160'(mst_w_o.last), 160'(exp_w[0].last));
      void'(exp_w.pop_front());
    end
  endtask

  // B is combinational, so the value driven on one edge is seen at the next
  task automatic check_b_passthrough();
    b_chan_t b;
    logic    valid;
    logic    ready;
    for (int unsigned i = 0; i < 4; i++) begin
      b.id          = id_t'(3 * i + 1);
      b.resp        = resp_t'(i);
      valid         = (i != 2);
      ready         = i[0];
      mst_b_i       <= b;
      mst_b_valid_i <= valid;
      slv_b_ready_i <= ready;
      @(posedge clk_i);
      check_value("slv_b_o.id", 160'(slv_b_o.id), 160'(b.id));
      check_value("slv_b_o.resp", 160'(slv_b_o.resp), 160'(b.resp));
      check_value("slv_b_valid_o", 160'(slv_b_valid_o), 160'(valid));
      check_value("mst_b_ready_o", 160'(mst_b_ready_o), 160'(ready));
    end
    mst_b_valid_i <= 1'b0;
  endtask

  // Random back-pressure on the wide side
  initial begin
    void'($urandom(38));
    wait (rst_ni === 1'b1);
    forever begin
      @(posedge clk_i);
      mst_aw_ready_i <= ($urandom % 4) != 0;
      mst_w_ready_i  <= ($urandom % 3) != 0;
    end
  end

  // Monitor and cycle limit
  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > timeout_cycles) begin
        abort_run($sformatf("Timed out after %0d cycles with %0d AW and %0d W beats missing",
                            cycle_count, exp_aw.size(), exp_w.size()));
      end else begin
        if (mst_aw_valid_o && mst_aw_ready_i) begin
          check_aw_beat();
        end
        if (mst_w_valid_o && mst_w_ready_i) begin
          check_w_beat();
        end
      end
    end
  end

  // AW requests run ahead of their data
  initial begin
    aw_done = 1'b0;
    wait (rst_ni === 1'b1);
    @(posedge clk_i);
    for (int unsigned r = 0; r < num_rows; r++) begin
      slv_aw_valid_i <= 1'b1;
      slv_aw_i       <= row_request(stim_table[r]);
      @(posedge clk_i);
      while (!slv_aw_ready_o) begin
        @(posedge clk_i);
      end
    end
    slv_aw_valid_i <= 1'b0;
    aw_done = 1'b1;
  end

  initial begin
    w_done = 1'b0;
    wait (rst_ni === 1'b1);
    @(posedge clk_i);
    for (int unsigned r = 0; r < num_rows; r++) begin
      for (int unsigned k = 0; k <= 32'(stim_table[r].len); k++) begin
        slv_w_valid_i <= 1'b1;
        slv_w_i       <= narrow_beat(stim_table[r], k);
        @(posedge clk_i);
        while (!slv_w_ready_o) begin
          @(posedge clk_i);
        end
      end
    end
    slv_w_valid_i <= 1'b0;
    w_done = 1'b1;
  end

  initial begin
    cycle_count    = 0;
    rst_ni         <= 1'b0;
    slv_aw_i       <= '0;
    slv_aw_valid_i <= 1'b0;
    slv_w_i        <= '0;
    slv_w_valid_i  <= 1'b0;
    slv_b_ready_i  <= 1'b0;
    mst_aw_ready_i <= 1'b0;
    mst_w_ready_i  <= 1'b0;
    mst_b_i        <= '0;
    mst_b_valid_i  <= 1'b0;
    load_table();
    for (int unsigned r = 0; r < num_rows; r++) begin
      exp_aw.push_back(expected_aw(stim_table[r]));
      queue_expected_w(stim_table[r]);
    end
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_value("mst_aw_valid_o", 160'(mst_aw_valid_o), 160'(1'b0));
    check_value("mst_w_valid_o", 160'(mst_w_valid_o), 160'(1'b0));
    check_value("slv_w_ready_o", 160'(slv_w_ready_o), 160'(1'b0));
    while (!(aw_done && w_done) || (exp_aw.size() != 0) || (exp_w.size() != 0)) begin
      @(posedge clk_i);
    end
    check_b_passthrough();
    $display("test passed");
    $finish;
  end

endmodule

// File: build.f
+incdir+.
upsizer_pkg.sv
burst_planner.sv
burst_desc_fifo.sv
write_packer.sv
dw_write_upsizer.sv
tb_dw_write_upsizer.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the upsizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_dw_write_upsizer -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
